/* crc_engine.f */
hdl/crc_pkg.sv
hdl/crc_byte_if.sv
hdl/crc_cfg_if.sv
hdl/crc_byte_ingress.sv
hdl/crc_xor_shift_cascade.sv
hdl/crc_byte_engine.sv
hdl/crc_apb_regs.sv
hdl/crc_engine_top.sv
bench/crc_engine_tb.sv

/* bench/crc_engine_tb.sv */
/*
 * CRC engine testbench
 * APB and byte stream drivers, bitwise CRC reference model,
 * assertion checks on results, register readback and handshakes
 */
module crc_engine_tb import crc_pkg::*;;

    // About 60 frames of up to 32 bytes with stalls, four times over
    localparam int MAX_CYCLES = 40000;

    logic        clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        in_valid;
    logic        in_ready;
    logic [7:0]  in_data;
    logic        in_last;
    logic        result_valid;
    logic        result_ready;
    logic [31:0] result;

    integer      seed = 93;
    int          cycles = 0;
    int          results_sent = 0;
    int          results_seen = 0;
    logic        stall_results = 1'b1;
    logic        next_ready;
    logic        in_ready_dropped = 1'b0;
    logic        hold_pending = 1'b0;
    logic [31:0] held_result;
    logic [31:0] last_result = '0;
    logic [31:0] exp_q[$];
    logic [7:0]  frame_bytes[$];

    // Configuration mirrored from the APB writes
    logic [31:0] cfg_poly = '0;
    logic [31:0] cfg_init = '0;
    logic [31:0] cfg_xorout = '0;
    logic [1:0]  cfg_ctrl = '0;

    crc_engine_top #(
        .CRC_WIDTH(32)
    ) crc_engine_top_i (
        .clk(clk), .reset(reset),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .in_valid(in_valid), .in_ready(in_ready), .in_data(in_data), .in_last(in_last),
        .result_valid(result_valid), .result_ready(result_ready), .result(result)
    );

    ////////////////////////////////////////
    // Error reporting
    ////////////////////////////////////////
    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic report_fail(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        report_error($sformatf("Fail at %0t: %s expected %h got %h",
                               $time, name, expected, actual));
    endtask

    ////////////////////////////////////////
    // Clock, timeout, monitors
    ////////////////////////////////////////
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            report_error($sformatf("Timeout after %0d cycles", cycles));
        end
    end

    // Zero wait states on every access phase
    assert property (@(posedge clk) psel && penable |-> pready)
        else report_error("pready low in an APB access phase");

    // A waiting result is not withdrawn
    assert property (@(posedge clk) disable iff (reset)
                     result_valid && !result_ready |=> result_valid)
        else report_error("result_valid dropped before the result handshake");

    always @(posedge clk) begin
        if (!reset && hold_pending) begin
            assert (result === held_result) else report_fail("result", held_result, result);
        end
        hold_pending = !reset && result_valid && !result_ready;
        held_result  = result;
        if (!reset && in_ready === 1'b0) begin
            in_ready_dropped = 1'b1;
        end
        // Result handshake against the model, oldest frame first
        if (!reset && result_valid && result_ready) begin
            if (exp_q.size() == 0) begin
                report_error("Result handed off with no frame outstanding");
            end
            assert (result === exp_q[0]) else report_fail("result", exp_q[0], result);
            last_result = exp_q.pop_front();
            results_seen++;
        end
    end

    // Random result back-pressure, about one cycle in four
    // Drawn on the rising edge, applied on the falling edge
    initial begin
        result_ready = 1'b0;
        forever begin
            @(posedge clk);
            next_ready = (({$random(seed)} % 4) != 0) && !stall_results;
            @(negedge clk);
            result_ready = next_ready;
        end
    end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    // Plain bit-at-a-time CRC over frame_bytes
    function automatic logic [31:0] crc_ref();
        logic [31:0] crc;
        logic [31:0] flipped;
        logic [7:0]  b;
        logic        data_bit;
        crc = cfg_init;
        foreach (frame_bytes[n]) begin
            b = frame_bytes[n];
            for (int i = 7; i >= 0; i--) begin
                // Reflected input goes LSB first
                data_bit = cfg_ctrl[CTRL_REFLECT_IN] ? b[7-i] : b[i];
                if (crc[31] != data_bit) begin
                    crc = (crc << 1) ^ cfg_poly;
                end else begin
                    crc = crc << 1;
                end
            end
        end
        for (int i = 0; i < 32; i++) begin
            flipped[i] = crc[31-i];
        end
        if (cfg_ctrl[CTRL_REFLECT_OUT]) begin
            crc = flipped;
        end
        return crc ^ cfg_xorout;
    endfunction

    ////////////////////////////////////////
    // APB and stream drivers
    ////////////////////////////////////////
    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic exp_err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        assert (pslverr === exp_err) else report_fail("pslverr", exp_err, pslverr);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_reg(input logic [7:0] addr, input string name,
                             input logic [31:0] expected, input logic exp_err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        assert (pslverr === exp_err) else report_fail("pslverr", exp_err, pslverr);
        assert (prdata === expected) else report_fail(name, expected, prdata);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic program_config();
        apb_write(REG_POLY, cfg_poly, 1'b0);
        apb_write(REG_INIT, cfg_init, 1'b0);
        apb_write(REG_XOROUT, cfg_xorout, 1'b0);
        apb_write(REG_CTRL, {30'b0, cfg_ctrl}, 1'b0);
    endtask

    // Sends frame_bytes, optionally with random idle gaps
    task automatic send_frame(input logic gaps);
        exp_q.push_back(crc_ref());
        results_sent++;
        foreach (frame_bytes[n]) begin
            if (gaps) begin
                repeat ({$random(seed)} % 4) @(negedge clk);
            end
            @(negedge clk);
            in_valid = 1'b1;
            in_data  = frame_bytes[n];
            in_last  = (n == frame_bytes.size() - 1);
            @(posedge clk);
            while (!in_ready) @(posedge clk);
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    task automatic wait_results();
        while (results_seen != results_sent) @(negedge clk);
    endtask

    task automatic check_status(input logic busy);
        check_reg(REG_STATUS, "prdata STATUS", {16'(results_seen), 15'b0, busy}, 1'b0);
    endtask

    // Standard check string with the result held back for a busy check
    task automatic check_value(input logic [31:0] expected);
        string text;
        text = "123456789";
        frame_bytes.delete();
        for (int n = 0; n < text.len(); n++) begin
            frame_bytes.push_back(text[n]);
        end
        assert (crc_ref() === expected) else report_fail("model check value", expected, crc_ref());
        program_config();
        stall_results = 1'b1;
        send_frame(1'b1);
        @(posedge clk);
        while (!result_valid) @(posedge clk);
        check_status(1'b1);
        stall_results = 1'b0;
        wait_results();
        check_status(1'b0);
        check_reg(REG_RESULT, "prdata RESULT", expected, 1'b0);
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////
    initial begin
        reset = 1'b1;
        {psel, penable, pwrite, paddr, pwdata} = '0;
        {in_valid, in_data, in_last} = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Reset values, readback, bad accesses
        assert (result_valid === 1'b0) else report_fail("result_valid", 0, result_valid);
        check_reg(REG_CTRL, "prdata CTRL", 0, 1'b0);
        check_reg(REG_POLY, "prdata POLY", 0, 1'b0);
        check_reg(REG_INIT, "prdata INIT", 0, 1'b0);
        check_reg(REG_XOROUT, "prdata XOROUT", 0, 1'b0);
        check_reg(REG_STATUS, "prdata STATUS", 0, 1'b0);
        check_reg(REG_RESULT, "prdata RESULT", 0, 1'b0);
        apb_write(REG_POLY, 32'h1234_5678, 1'b0);
        apb_write(REG_INIT, 32'h9ABC_DEF0, 1'b0);
        apb_write(REG_XOROUT, 32'h0F0F_A5A5, 1'b0);
        apb_write(REG_CTRL, 32'hFFFF_FFFF, 1'b0);
        apb_write(REG_STATUS, 32'hFFFF_FFFF, 1'b1);
        apb_write(REG_RESULT, 32'hFFFF_FFFF, 1'b1);
        apb_write(8'h18, 32'hFFFF_FFFF, 1'b1);
        check_reg(8'h18, "prdata unmapped", 0, 1'b1);
        check_reg(REG_POLY, "prdata POLY", 32'h1234_5678, 1'b0);
        check_reg(REG_INIT, "prdata INIT", 32'h9ABC_DEF0, 1'b0);
        check_reg(REG_XOROUT, "prdata XOROUT", 32'h0F0F_A5A5, 1'b0);
        check_reg(REG_CTRL, "prdata CTRL", 32'h3, 1'b0);
        check_reg(REG_STATUS, "prdata STATUS", 0, 1'b0);
        check_reg(REG_RESULT, "prdata RESULT", 0, 1'b0);

        // CRC-32, then CRC-32/MPEG-2
        {cfg_poly, cfg_init, cfg_xorout, cfg_ctrl} =
            {32'h04C1_1DB7, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 2'b11};
        check_value(32'hCBF4_3926);
        {cfg_poly, cfg_init, cfg_xorout, cfg_ctrl} =
            {32'h04C1_1DB7, 32'hFFFF_FFFF, 32'h0, 2'b00};
        check_value(32'h0376_E6E7);

        // Random frames and configurations
        for (int f = 0; f < 50; f++) begin
            cfg_poly   = $random(seed);
            cfg_init   = $random(seed);
            cfg_xorout = $random(seed);
            cfg_ctrl   = $random(seed);
            program_config();
            frame_bytes.delete();
            repeat (1 + {$random(seed)} % 32) frame_bytes.push_back($random(seed));
            send_frame(1'b1);
            wait_results();
            check_reg(REG_RESULT, "prdata RESULT", last_result, 1'b0);
            check_status(1'b0);
        end

        // One-byte frames against a long result stall
        stall_results = 1'b1;
        in_ready_dropped = 1'b0;
        fork
            for (int f = 0; f < 8; f++) begin
                frame_bytes.delete();
                frame_bytes.push_back($random(seed));
                send_frame(1'b0);
            end
            begin
                repeat (80) @(negedge clk);
                if (!in_ready_dropped) begin
                    report_error("in_ready never dropped under a result stall");
                end
                stall_results = 1'b0;
            end
        join
        wait_results();
        // Both buffer entries drained once every result is out
        assert (in_ready === 1'b1) else report_fail("in_ready", 1, in_ready);
        check_status(1'b0);

        $display("PASS: all tests");
        $finish;
    end

endmodule : crc_engine_tb

/* hdl/crc_engine_top.sv */
/*
 * Streaming CRC engine
 * Byte ingress, byte-wide CRC fold and APB configuration block
 */
module crc_engine_top import crc_pkg::*; #(
    parameter int CRC_WIDTH = 32
) (
    input  logic                      clk,
    input  logic                      reset,

    // APB slave
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [APB_ADDR_WIDTH-1:0] paddr,
    input  logic [31:0]               pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr,

    // Byte stream in
    input  logic                      in_valid,
    output logic                      in_ready,
    input  logic [7:0]                in_data,
    input  logic                      in_last,

    // CRC result out
    output logic                      result_valid,
    input  logic                      result_ready,
    output logic [CRC_WIDTH-1:0]      result
);

    ////////////////////////////////////////
    // Internal channels
    ////////////////////////////////////////
    crc_byte_if byte_if ();

    crc_cfg_if #(
        .CRC_WIDTH(CRC_WIDTH)
    ) cfg_if ();

    ////////////////////////////////////////
    // Blocks
    ////////////////////////////////////////
    // Input side
    crc_byte_ingress crc_byte_ingress_i (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_data  (in_data),
        .in_last  (in_last),
        .out      (byte_if.source)
    );

    // CRC fold and result hand-off
    crc_byte_engine #(
        .CRC_WIDTH(CRC_WIDTH)
    ) crc_byte_engine_i (
        .clk          (clk),
        .reset        (reset),
        .in           (byte_if.sink),
        .cfg          (cfg_if.engine),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result       (result)
    );

    // Configuration and readback
    crc_apb_regs #(
        .CRC_WIDTH(CRC_WIDTH)
    ) crc_apb_regs_i (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cfg     (cfg_if.regs)
    );

endmodule : crc_engine_top

/* hdl/crc_apb_regs.sv */
/*
 * CRC engine APB register block
 * Holds the CRC configuration, last finished result and frame count
 */
module crc_apb_regs import crc_pkg::*; #(
    parameter int CRC_WIDTH = 32
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [APB_ADDR_WIDTH-1:0] paddr,
    input  logic [31:0]               pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr,
    crc_cfg_if.regs                   cfg
);

    // Configuration
    logic                         reflect_in;
    logic                         reflect_out;
    logic [CRC_WIDTH-1:0]         poly;
    logic [CRC_WIDTH-1:0]         init;
    logic [CRC_WIDTH-1:0]         xorout;
    // Readback of finished frames
    logic [CRC_WIDTH-1:0]         last_crc;
    logic [FRAME_COUNT_WIDTH-1:0] frame_count;

    logic access;
    logic mapped;
    logic read_only;
    logic wr_en;

    ////////////////////////////////////////
    // Decode
    ////////////////////////////////////////
    assign access = psel && penable;

    always_comb begin
        mapped    = 1'b1;
        read_only = 1'b0;
        case (paddr)
            REG_CTRL, REG_POLY, REG_INIT, REG_XOROUT: read_only = 1'b0;
            REG_STATUS, REG_RESULT:                   read_only = 1'b1;
            default:                                  mapped    = 1'b0;
        endcase
    end

    // Zero wait states
    assign pready  = 1'b1;
    assign pslverr = access && (!mapped || (pwrite && read_only));
    // Bad writes are dropped
    assign wr_en   = access && pwrite && mapped && !read_only;

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            reflect_in  <= 1'b0;
            reflect_out <= 1'b0;
            poly        <= '0;
            init        <= '0;
            xorout      <= '0;
            last_crc    <= '0;
            frame_count <= '0;
        end else begin
            if (wr_en) begin
                case (paddr)
                    REG_CTRL: begin
                        reflect_in  <= pwdata[CTRL_REFLECT_IN];
                        reflect_out <= pwdata[CTRL_REFLECT_OUT];
                    end
                    REG_POLY:   poly   <= pwdata[CRC_WIDTH-1:0];
                    REG_INIT:   init   <= pwdata[CRC_WIDTH-1:0];
                    REG_XOROUT: xorout <= pwdata[CRC_WIDTH-1:0];
                    default: ;
                endcase
            end
            // Result hand-off from the engine
            if (cfg.done) begin
                last_crc    <= cfg.done_crc;
                frame_count <= frame_count + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Readback
    ////////////////////////////////////////
    always_comb begin
        prdata = '0;
        case (paddr)
            REG_CTRL: begin
                prdata[CTRL_REFLECT_IN]  = reflect_in;
                prdata[CTRL_REFLECT_OUT] = reflect_out;
            end
            // Narrow CRCs read back zero-extended
            REG_POLY:   prdata = 32'(poly);
            REG_INIT:   prdata = 32'(init);
            REG_XOROUT: prdata = 32'(xorout);
            REG_STATUS: begin
                prdata[STATUS_BUSY] = cfg.busy;
                prdata[STATUS_COUNT_LSB +: FRAME_COUNT_WIDTH] = frame_count;
            end
            REG_RESULT: prdata = 32'(last_crc);
            default:    prdata = '0;
        endcase
    end

    // Settings out to the engine
    assign cfg.poly        = poly;
    assign cfg.init        = init;
    assign cfg.xorout      = xorout;
    assign cfg.reflect_in  = reflect_in;
    assign cfg.reflect_out = reflect_out;

endmodule : crc_apb_regs

/* hdl/crc_byte_engine.sv */
/*
 * CRC byte engine
 * Folds one byte per beat into the CRC state, applies the output
 * reflection and XOR at frame end, then holds the result for hand-off
 */
module crc_byte_engine #(
    parameter int CRC_WIDTH = 32
) (
    input  logic                 clk,
    input  logic                 reset,
    crc_byte_if.sink             in,
    crc_cfg_if.engine            cfg,
    output logic                 result_valid,
    input  logic                 result_ready,
    output logic [CRC_WIDTH-1:0] result
);

    // Running CRC between beats
    logic [CRC_WIDTH-1:0] state;
    // Set by the first byte, cleared by the hand-off
    logic                 busy;

    logic                 beat;
    logic                 handoff;
    logic [7:0]           byte_in;
    logic [CRC_WIDTH-1:0] seed;
    logic [CRC_WIDTH-1:0] next_state;
    logic [CRC_WIDTH-1:0] final_crc;

    ////////////////////////////////////////
    // Bit reversal helpers
    ////////////////////////////////////////
    function automatic logic [7:0] reverse_byte(input logic [7:0] value);
        logic [7:0] flipped;
        for (int i = 0; i < 8; i++) begin
            flipped[i] = value[7-i];
        end
        return flipped;
    endfunction

    function automatic logic [CRC_WIDTH-1:0] reverse_crc(
        input logic [CRC_WIDTH-1:0] value
    );
        logic [CRC_WIDTH-1:0] flipped;
        for (int i = 0; i < CRC_WIDTH; i++) begin
            flipped[i] = value[CRC_WIDTH-1-i];
        end
        return flipped;
    endfunction

    // Stall the stream while a result waits
    assign in.ready = !result_valid;

    assign beat    = in.valid && in.ready;
    assign handoff = result_valid && result_ready;

    ////////////////////////////////////////
    // Data path
    ////////////////////////////////////////
    // Input reflection
    assign byte_in = cfg.reflect_in ? reverse_byte(in.data) : in.data;
    // First byte of a frame starts from init
    assign seed    = busy ? state : cfg.init;

    crc_xor_shift_cascade #(
        .CRC_WIDTH(CRC_WIDTH)
    ) crc_xor_shift_cascade_i (
        .block_input  (seed),
        .poly         (cfg.poly),
        .data_input   (byte_in),
        .block_output (next_state)
    );

    // Output reflection, then output XOR
    assign final_crc = (cfg.reflect_out ? reverse_crc(next_state) : next_state) ^
                       cfg.xorout;

    always_ff @(posedge clk) begin
        if (beat) begin
            state <= next_state;
        end
        // Captured once, held until hand-off
        if (beat && in.last) begin
            result <= final_crc;
        end
    end

    ////////////////////////////////////////
    // Frame control
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            busy         <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            if (beat) begin
                busy <= 1'b1;
            end
            if (beat && in.last) begin
                result_valid <= 1'b1;
            end
            // Next frame may start right after this
            if (handoff) begin
                busy         <= 1'b0;
                result_valid <= 1'b0;
            end
        end
    end

    // Status toward the register block
    assign cfg.busy     = busy;
    assign cfg.done     = handoff;
    assign cfg.done_crc = result;

endmodule : crc_byte_engine

/* hdl/crc_xor_shift_cascade.sv */
/*
 * CRC byte fold
 * Eight chained bit-serial XOR/shift steps, MSB of the data first
 */
module crc_xor_shift_cascade #(
    parameter int CRC_WIDTH = 32
) (
    input  logic [CRC_WIDTH-1:0] block_input,
    input  logic [CRC_WIDTH-1:0] poly,
    input  logic [7:0]           data_input,
    output logic [CRC_WIDTH-1:0] block_output
);

    // Stage 0 is the incoming state, stage 8 the folded result
    logic [CRC_WIDTH-1:0] stage [0:8];

    assign stage[0] = block_input;

    ////////////////////////////////////////
    // Bit steps
    ////////////////////////////////////////
    for (genvar i = 0; i < 8; i++) begin : gen_step
        // Outgoing top bit against the data bit of this step
        logic feedback;

        assign feedback = stage[i][CRC_WIDTH-1] ^ data_input[7-i];

        // Shift left, then apply the polynomial on feedback
        assign stage[i+1] = {stage[i][CRC_WIDTH-2:0], 1'b0} ^
                            (feedback ? poly : '0);
    end

    assign block_output = stage[8];

endmodule : crc_xor_shift_cascade

/* hdl/crc_byte_ingress.sv */
/*
 * Byte stream ingress
 * Two-entry skid buffer, registered ready toward the external source
 */
module crc_byte_ingress (
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    output logic        in_ready,
    input  logic [7:0]  in_data,
    input  logic        in_last,
    crc_byte_if.source  out
);

    // Main entry, seen by the engine
    logic       main_valid;
    logic [7:0] main_data;
    logic       main_last;
    // Spill entry, occupied whenever in_ready is low
    logic [7:0] spill_data;
    logic       spill_last;

    logic accept;
    logic pop;

    assign accept = in_valid && in_ready;
    assign pop    = main_valid && out.ready;

    ////////////////////////////////////////
    // Occupancy
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            main_valid <= 1'b0;
            in_ready   <= 1'b1;
        end else if (!main_valid || pop) begin
            // Main slot frees up, spill moves forward first
            if (!in_ready) begin
                main_valid <= 1'b1;
                in_ready   <= 1'b1;
            end else begin
                main_valid <= accept;
            end
        end else if (accept) begin
            // Engine stalled, park the byte
            in_ready <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // Payload
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!main_valid || pop) begin
            if (!in_ready) begin
                main_data <= spill_data;
                main_last <= spill_last;
            end else if (accept) begin
                main_data <= in_data;
                main_last <= in_last;
            end
        end else if (accept) begin
            spill_data <= in_data;
            spill_last <= in_last;
        end
    end

    // Oldest entry always sits in main
    assign out.valid = main_valid;
    assign out.data  = main_data;
    assign out.last  = main_last;

endmodule : crc_byte_ingress

/* hdl/crc_cfg_if.sv */
/*
 * Configuration and frame status channel
 * Register block to engine settings, engine to register block status
 */
interface crc_cfg_if #(
    parameter int CRC_WIDTH = 32
);

    // Programmed settings
    logic [CRC_WIDTH-1:0] poly;
    logic [CRC_WIDTH-1:0] init;
    logic [CRC_WIDTH-1:0] xorout;
    logic                 reflect_in;
    logic                 reflect_out;

    // Frame in progress
    logic                 busy;
    // Single-cycle pulse on result hand-off
    logic                 done;
    // Finished CRC, valid with done
    logic [CRC_WIDTH-1:0] done_crc;

    modport regs (
        output poly, init, xorout, reflect_in, reflect_out,
        input  busy, done, done_crc
    );

    modport engine (
        input  poly, init, xorout, reflect_in, reflect_out,
        output busy, done, done_crc
    );

endinterface : crc_cfg_if

/* hdl/crc_byte_if.sv */
/*
 * Byte beat channel
 * One data byte with frame end flag, valid/ready handshake
 */
interface crc_byte_if;

    // Beat qualifier and back-pressure
    logic       valid;
    logic       ready;

    // Payload
    logic [7:0] data;
    logic       last;

    // Ingress side drives the beat
    modport source (
        output valid, data, last,
        input  ready
    );

    // Engine side consumes it
    modport sink (
        input  valid, data, last,
        output ready
    );

endinterface : crc_byte_if

/* hdl/crc_pkg.sv */
/*
 * CRC engine shared definitions
 * APB register map, control and status bit positions, frame counter width
 */
package crc_pkg;

    ////////////////////////////////////////
    // APB bus
    ////////////////////////////////////////
    localparam int APB_ADDR_WIDTH = 8;

    // Register byte offsets, one per 32-bit word
    localparam logic [APB_ADDR_WIDTH-1:0] REG_CTRL   = 8'h00;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_POLY   = 8'h04;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_INIT   = 8'h08;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_XOROUT = 8'h0C;
    // Read-only below
    localparam logic [APB_ADDR_WIDTH-1:0] REG_STATUS = 8'h10;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_RESULT = 8'h14;

    ////////////////////////////////////////
    // Field positions
    ////////////////////////////////////////
    // CTRL bits
    localparam int CTRL_REFLECT_IN  = 0;
    localparam int CTRL_REFLECT_OUT = 1;

    // STATUS bits, frame count in the upper half
    localparam int STATUS_BUSY      = 0;
    localparam int STATUS_COUNT_LSB = 16;

    // Finished frame counter, wraps around
    localparam int FRAME_COUNT_WIDTH = 16;

endpackage : crc_pkg
